/* qtuFmb.f */
logic/qtuPkg.sv
logic/neighborTable.sv
logic/nextHopSelector.sv
logic/responseMerger.sv
logic/qtuFmb.sv
verification/clockGen.sv
verification/qtuFmb_properties.sv
verification/qtuFmbTb.sv

/* run.sh */
#!/bin/sh
# compile the qtuFmb testbench with Verilator and run it
# a $fatal or a failed assertion gives a nonzero exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module qtuFmbTb -f qtuFmb.f -o qtuFmbSim
./obj_dir/qtuFmbSim

/* verification/qtuFmbTb.sv */
module qtuFmbTb import qtuPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    // one expected response tagged with the cycle of its strobe
    typedef struct {
        neighborRecord rec;
        nodeWord       hop;
        int unsigned   issue;
    } expectEntry;

    logic          clk;
    logic          nrst;
    logic          en;
    logic          hbReset;
    logic          iAmDestination;
    packetInfo     pkt;
    nodeWord       myChosenCh;
    nodeWord       myHopsFromCh;
    neighborRecord rec;
    nodeWord       chosenHop;
    logic          done;

    // reference model state
    logic [31:0]   modelValid;
    nodeWord       modelId [32];
    nodeWord       modelMaxQ;
    nodeWord       modelBest;
    // at most two responses in flight
    expectEntry    expectQ [$];
    int unsigned   cycleCount;

    clockGen i_clockGen (
        .clk  (clk),
        .nrst (nrst)
    );

    qtuFmb #(
        .tableDepth (32)
    ) i_dut (
        .clk            (clk),
        .nrst           (nrst),
        .en             (en),
        .hbReset        (hbReset),
        .iAmDestination (iAmDestination),
        .pkt            (pkt),
        .myChosenCh     (myChosenCh),
        .myHopsFromCh   (myHopsFromCh),
        .rec            (rec),
        .chosenHop      (chosenHop),
        .done           (done)
    );

    bind qtuFmb qtuFmbProperties i_props (
        .clk       (clk),
        .nrst      (nrst),
        .en        (en),
        .hbReset   (hbReset),
        .chosenHop (chosenHop),
        .done      (done)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkRecord(input neighborRecord got, input neighborRecord exp);
        if (got !== exp) begin
            abortRun($sformatf("** Error: rec = %h, expected %h", got, exp));
        end
    endtask

    task automatic checkHop(input string name, input nodeWord got, input nodeWord exp);
        if (got !== exp) begin
            abortRun($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    // member packets reuse a matching slot or take the lowest free one
    task automatic modelTable(input packetInfo p, output neighborRecord r);
        int hit;
        int free;
        r            = '0;
        r.nodeId     = p.sourceId;
        r.nodeHops   = p.sourceHops;
        r.nodeEnergy = p.energyLeft;
        r.nodeQValue = p.qValue;
        hit          = -1;
        free         = -1;
        for (int i = 0; i < 32; i++) begin
            if (modelValid[i] && modelId[i] == p.sourceId) hit = i;
        end
        for (int i = 31; i >= 0; i--) begin
            if (!modelValid[i]) free = i;
        end
        if (p.chosenCh == myChosenCh && hit >= 0) begin
            r.neighborIndex = 5'(hit);
            r.stored        = 1'b1;
        end else if (p.chosenCh == myChosenCh && free >= 0) begin
            modelValid[free] = 1'b1;
            modelId[free]    = p.sourceId;
            r.neighborIndex  = 5'(free);
            r.stored         = 1'b1;
        end
    endtask

    // cluster head when adjacent or else the best q one hop nearer with lower id on ties
    task automatic modelNextHop(input packetInfo p, input logic dest, output nodeWord hop);
        nodeWord needed;
        needed = myHopsFromCh - 16'd1;
        if (dest && myHopsFromCh == 16'd1) begin
            modelBest = myChosenCh;
        end else if (dest && p.hopsFromCh == needed && (p.qValue > modelMaxQ ||
                     (p.qValue == modelMaxQ && p.sourceId < modelBest))) begin
            modelMaxQ = p.qValue;
            modelBest = p.sourceId;
        end
        hop = modelBest;
    endtask

    function automatic packetInfo makePacket(input nodeWord id, input nodeWord ch,
                                             input nodeWord hops, input nodeWord q);
        packetInfo p;
        p.sourceId   = id;
        p.sourceHops = hops + 16'd1;
        p.qValue     = q;
        p.energyLeft = nodeWord'($urandom);
        p.hopsFromCh = hops;
        p.chosenCh   = ch;
        return p;
    endfunction

    // small id pool and q range make repeats and ties common
    function automatic packetInfo randomPacket(input int unsigned pool,
                                               input int unsigned memberPct);
        packetInfo p;
        p.sourceId   = 16'h0040 + nodeWord'($urandom_range(pool - 1, 0));
        p.sourceHops = nodeWord'($urandom_range(9, 0));
        p.qValue     = nodeWord'($urandom_range(7, 0));
        p.energyLeft = nodeWord'($urandom);
        // two hops nearer up to our own hop count
        p.hopsFromCh = myHopsFromCh + nodeWord'($urandom_range(2, 0)) - 16'd2;
        p.chosenCh   = ($urandom_range(99, 0) < memberPct) ? myChosenCh : myChosenCh + 16'd1;
        return p;
    endfunction

    // one clock then check whatever response shows up
    task automatic advance();
        expectEntry e;
        @(posedge clk);
        #2;
        cycleCount++;
        if (done && expectQ.size() == 0) begin
            abortRun("done pulsed with no packet in flight");
        end else if (done) begin
            e = expectQ.pop_front();
            if (cycleCount != e.issue + 2) begin
                abortRun("done came at the wrong cycle after its strobe");
            end else begin
                checkRecord(rec, e.rec);
                checkHop("chosenHop", chosenHop, e.hop);
            end
        end else if (expectQ.size() != 0 && cycleCount >= expectQ[0].issue + 2) begin
            abortRun("done missing two edges after a strobe");
        end
    endtask

    task automatic sendPacket(input packetInfo p, input logic dest);
        expectEntry e;
        en             = 1'b1;
        hbReset        = 1'b0;
        iAmDestination = dest;
        pkt            = p;
        modelTable(p, e.rec);
        modelNextHop(p, dest, e.hop);
        e.issue = cycleCount;
        expectQ.push_back(e);
        advance();
    endtask

    task automatic idleCycle();
        en      = 1'b0;
        hbReset = 1'b0;
        advance();
    endtask

    // heartbeat clear drops a packet on the same edge
    task automatic pulseHeartbeat(input logic withPacket);
        en         = withPacket;
        hbReset    = 1'b1;
        pkt        = randomPacket(8, 90);
        modelValid = '0;
        modelMaxQ  = '0;
        modelBest  = noNode;
        advance();
    endtask

    task automatic drainResponses();
        int waited;
        waited = 0;
        while (expectQ.size() != 0 && waited < 8) begin
            idleCycle();
            waited++;
        end
        if (expectQ.size() != 0) begin
            abortRun("timeout: done never came for a queued packet");
        end
    endtask

    task automatic waitReset();
        int waited;
        waited = 0;
        while (nrst !== 1'b1 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (nrst !== 1'b1) begin
            abortRun("timeout: reset was never released");
        end else begin
            #2;
        end
    endtask

    initial begin
        int unsigned sel;
        void'($urandom(32'h29a9_4831));
        en             = 1'b0;
        hbReset        = 1'b0;
        iAmDestination = 1'b0;
        pkt            = '0;
        myChosenCh     = 16'h00C1;
        myHopsFromCh   = 16'd3;
        modelValid     = '0;
        modelMaxQ      = '0;
        modelBest      = noNode;
        cycleCount     = 0;
        waitReset();
        if (done !== 1'b0) abortRun("done high right after reset");
        checkRecord(rec, '0);
        checkHop("chosenHop", chosenHop, noNode);

        // back to back fill of slots 0..2 and one repeat
        sendPacket(makePacket(16'h0010, myChosenCh, 16'd2, 16'd5), 1'b0);
        sendPacket(makePacket(16'h0011, myChosenCh, 16'd2, 16'd3), 1'b0);
        sendPacket(makePacket(16'h0012, myChosenCh, 16'd3, 16'd1), 1'b0);
        sendPacket(makePacket(16'h0011, myChosenCh, 16'd2, 16'd4), 1'b0);
        drainResponses();

        // foreign cluster packets allocate nothing
        for (int i = 0; i < 4; i++) begin
            sendPacket(makePacket(16'h0020 + nodeWord'(i), 16'h00C2, 16'd2, 16'd2), 1'b0);
        end
        // fill the remaining 29 slots and try one more new id
        for (int i = 0; i < 29; i++) begin
            sendPacket(makePacket(16'h0100 + nodeWord'(i), myChosenCh, 16'd2, 16'd2), 1'b0);
        end
        sendPacket(makePacket(16'h0300, myChosenCh, 16'd2, 16'd2), 1'b0);
        drainResponses();

        // cluster head one hop away
        myHopsFromCh = 16'd1;
        for (int i = 0; i < 6; i++) sendPacket(randomPacket(8, 80), 1'b1);
        drainResponses();
        checkHop("chosenHop", chosenHop, myChosenCh);

        // best q one hop nearer with some packets not addressed to us
        pulseHeartbeat(1'b0);
        myHopsFromCh = 16'd4;
        for (int i = 0; i < 200; i++) begin
            if ($urandom_range(3, 0) == 0) idleCycle();
            else sendPacket(randomPacket(8, 90), $urandom_range(3, 0) != 0);
        end
        drainResponses();

        // after a clear there is no hop yet and allocation restarts at slot 0
        pulseHeartbeat(1'b1);
        sendPacket(makePacket(16'h0050, myChosenCh, 16'd3, 16'd6), 1'b0);
        drainResponses();
        checkHop("chosenHop", chosenHop, noNode);

        // mixed traffic with a pool larger than the table
        myHopsFromCh = 16'd3;
        for (int i = 0; i < 300; i++) begin
            sel = $urandom_range(31, 0);
            if (sel == 0) pulseHeartbeat($urandom_range(1, 0) != 0);
            else if (sel < 6) idleCycle();
            else sendPacket(randomPacket(40, 85), $urandom_range(1, 0) != 0);
        end
        drainResponses();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* verification/qtuFmb_properties.sv */
module qtuFmbProperties import qtuPkg::*; (
    input logic    clk,
    input logic    nrst,
    input logic    en,
    input logic    hbReset,
    input nodeWord chosenHop,
    input logic    done
);
    timeunit 1ns;
    timeprecision 100ps;

    // every response traces back to an accepted packet
    doneHasCause: assert property (@(posedge clk) disable iff (!nrst)
        done |-> $past(en && !hbReset, 2))
        else $error("done without an accepted packet two edges earlier");

    // accepted packet always answered, fixed latency
    packetAnswered: assert property (@(posedge clk) disable iff (!nrst)
        (en && !hbReset) |-> ##2 done)
        else $error("accepted packet not answered two edges later");

    // output hop only moves together with a response
    hopStable: assert property (@(posedge clk) disable iff (!nrst)
        $changed(chosenHop) |-> done)
        else $error("chosenHop changed without done");

endmodule

/* verification/clockGen.sv */
module clockGen (
    output logic clk,
    output logic nrst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset low for three rising edges, released just after the third
    initial begin
        nrst = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        nrst = 1'b1;
    end

endmodule

/* logic/qtuFmb.sv */
module qtuFmb import qtuPkg::*; #(
    parameter int tableDepth = 32
) (
    input  logic          clk,
    input  logic          nrst,
    input  logic          en,
    input  logic          hbReset,
    input  logic          iAmDestination,
    input  packetInfo     pkt,
    input  nodeWord       myChosenCh,
    input  nodeWord       myHopsFromCh,
    output neighborRecord rec,
    output nodeWord       chosenHop,
    output logic          done
);

    // stage one results
    neighborRecord tableRec;
    logic          tableStrobe;
    nodeWord       bestHop;

    // q-table update side
    neighborTable #(
        .tableDepth (tableDepth)
    ) i_neighborTable (
        .clk         (clk),
        .nrst        (nrst),
        .en          (en),
        .hbReset     (hbReset),
        .pkt         (pkt),
        .myChosenCh  (myChosenCh),
        .tableRec    (tableRec),
        .tableStrobe (tableStrobe)
    );

    // next-hop search side, same strobe
    nextHopSelector i_nextHopSelector (
        .clk            (clk),
        .nrst           (nrst),
        .en             (en),
        .hbReset        (hbReset),
        .iAmDestination (iAmDestination),
        .pkt            (pkt),
        .myChosenCh     (myChosenCh),
        .myHopsFromCh   (myHopsFromCh),
        .bestHop        (bestHop)
    );

    // stage two, joint output register
    responseMerger i_responseMerger (
        .clk         (clk),
        .nrst        (nrst),
        .tableStrobe (tableStrobe),
        .tableRec    (tableRec),
        .bestHop     (bestHop),
        .rec         (rec),
        .chosenHop   (chosenHop),
        .done        (done)
    );

endmodule

/* logic/responseMerger.sv */
module responseMerger import qtuPkg::*; (
    input  logic          clk,
    input  logic          nrst,
    input  logic          tableStrobe,
    input  neighborRecord tableRec,
    input  nodeWord       bestHop,
    output neighborRecord rec,
    output nodeWord       chosenHop,
    output logic          done
);

    // both results are taken on the same edge
    // so rec and chosenHop always describe one packet
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rec       <= emptyRecord;
            chosenHop <= noNode;
        end else if (tableStrobe) begin
            rec       <= tableRec;
            chosenHop <= bestHop;
        end
    end

    // one pulse per captured response
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            done <= 1'b0;
        end else begin
            done <= tableStrobe;
        end
    end

endmodule

/* logic/nextHopSelector.sv */
module nextHopSelector import qtuPkg::*; (
    input  logic      clk,
    input  logic      nrst,
    input  logic      en,
    input  logic      hbReset,
    input  logic      iAmDestination,
    input  packetInfo pkt,
    input  nodeWord   myChosenCh,
    input  nodeWord   myHopsFromCh,
    output nodeWord   bestHop
);

    // hop count a useful neighbor must have
    nodeWord hopsNeeded;
    // best q-value seen among neighbors at hopsNeeded
    nodeWord maxQ;

    logic search;
    logic chAdjacent;
    logic nearer;
    logic better;

    assign hopsNeeded = myHopsFromCh - 16'd1;

    // only data packets addressed to us drive the search
    assign search     = en && iAmDestination;
    // cluster head is our direct neighbor
    assign chAdjacent = (myHopsFromCh == 16'd1);
    // sender sits one hop closer to the cluster head
    assign nearer     = (pkt.hopsFromCh == hopsNeeded);

    // higher q wins, lower id breaks a tie
    assign better = (pkt.qValue > maxQ) ||
                    ((pkt.qValue == maxQ) && (pkt.sourceId < bestHop));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            maxQ    <= '0;
            bestHop <= noNode;
        end else if (hbReset) begin
            // new cluster round, forget the old winner
            maxQ    <= '0;
            bestHop <= noNode;
        end else if (search) begin
            if (chAdjacent) begin
                bestHop <= myChosenCh;
            end else if (nearer && better) begin
                maxQ    <= pkt.qValue;
                bestHop <= pkt.sourceId;
            end
        end
    end

endmodule

/* logic/neighborTable.sv */
module neighborTable import qtuPkg::*; #(
    parameter int tableDepth = 32
) (
    input  logic          clk,
    input  logic          nrst,
    input  logic          en,
    input  logic          hbReset,
    input  packetInfo     pkt,
    input  nodeWord       myChosenCh,
    output neighborRecord tableRec,
    output logic          tableStrobe
);

    // index width, at least one bit
    localparam int idxW = (tableDepth > 1) ? $clog2(tableDepth) : 1;

    // valid tags and stored ids
    logic [tableDepth-1:0] slotValid;
    nodeWord               slotId [tableDepth];

    logic [tableDepth-1:0] hitVec;
    logic                  anyHit;
    logic                  anyFree;
    logic [idxW-1:0]       hitIdx;
    logic [idxW-1:0]       freeIdx;
    logic                  isMember;
    logic                  accept;
    logic                  writeNew;
    neighborRecord         nextRec;

    // only packets from our own cluster are kept
    assign isMember = (pkt.chosenCh == myChosenCh);
    // heartbeat clear wins over a packet in the same cycle
    assign accept   = en && !hbReset;

    // per-slot tag compare, all slots at once
    always_comb begin
        for (int i = 0; i < tableDepth; i++) begin
            hitVec[i] = slotValid[i] && (slotId[i] == pkt.sourceId);
        end
    end

    assign anyHit  = |hitVec;
    assign anyFree = ~&slotValid;

    // one-hot to index, ids are unique so at most one hit
    always_comb begin
        hitIdx = '0;
        for (int i = 0; i < tableDepth; i++) begin
            if (hitVec[i]) begin
                hitIdx = hitIdx | idxW'(i);
            end
        end
    end

    // lowest free slot, scan downwards so the last match is the lowest
    always_comb begin
        freeIdx = '0;
        for (int i = tableDepth - 1; i >= 0; i--) begin
            if (!slotValid[i]) begin
                freeIdx = idxW'(i);
            end
        end
    end

    assign writeNew = accept && isMember && !anyHit && anyFree;

    // record fields always mirror the packet
    always_comb begin
        nextRec            = emptyRecord;
        nextRec.nodeId     = pkt.sourceId;
        nextRec.nodeHops   = pkt.sourceHops;
        nextRec.nodeEnergy = pkt.energyLeft;
        nextRec.nodeQValue = pkt.qValue;
        if (isMember && anyHit) begin
            nextRec.neighborIndex = 5'(hitIdx);
            nextRec.stored        = 1'b1;
        end else if (isMember && anyFree) begin
            nextRec.neighborIndex = 5'(freeIdx);
            nextRec.stored        = 1'b1;
        end
    end

    // valid tags and strobe
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            slotValid   <= '0;
            tableStrobe <= 1'b0;
        end else begin
            tableStrobe <= accept;
            if (hbReset) begin
                slotValid <= '0;
            end else if (writeNew) begin
                slotValid[freeIdx] <= 1'b1;
            end
        end
    end

    // id storage and record register
    always_ff @(posedge clk) begin
        if (writeNew) begin
            slotId[freeIdx] <= pkt.sourceId;
        end
        if (accept) begin
            tableRec <= nextRec;
        end
    end

endmodule

/* logic/qtuPkg.sv */
package qtuPkg;

    // one word carries ids, hop counts, energy and q-values
    typedef logic [15:0] nodeWord;

    // marks an unknown node or an unreachable hop count
    localparam nodeWord noNode = 16'hFFFF;

    // fields of a received packet, as handed over by the packet filter
    typedef struct packed {
        nodeWord sourceId;
        nodeWord sourceHops;
        nodeWord qValue;
        nodeWord energyLeft;
        // sender distance to its cluster head
        nodeWord hopsFromCh;
        // cluster head the sender belongs to
        nodeWord chosenCh;
    } packetInfo;

    // entry written into the neighbor table
    typedef struct packed {
        nodeWord nodeId;
        nodeWord nodeHops;
        nodeWord nodeEnergy;
        nodeWord nodeQValue;
        // slot index, 5 bits caps the table at 32 entries
        logic [4:0] neighborIndex;
        // high when the packet landed in a slot
        logic stored;
    } neighborRecord;

    // cleared record
    localparam neighborRecord emptyRecord = '0;

endpackage
